/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module tb_top -o tb_top_sim
./obj_dir/tb_top_sim | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "Run FAILED, see sim.log"
    exit 1
fi

echo "Run passed"

/* src.f */
verilog/tc_cfg_pkg.sv
verilog/tc_ctrl_pkg.sv
verilog/burst_planner.sv
verilog/phase_sequencer.sv
verilog/mem_req_port.sv
verilog/tensor_sched_top.sv
testbench/clk_gen.sv
testbench/tensor_sched_asserts.sv
testbench/tb_top.sv

/* testbench/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;  // 100 ns period
        end
    end

endmodule

/* testbench/sched_golden.txt */
# shape type mixed c_num c_size a_num a_size b_num b_size latency
# shape 0..2 = M32K16N8 M16K16N16 M8K16N32, type 0..3 = FP32 FP16 INT8 INT4
0 0 0 31 5 63 5 15 5 75
0 1 0 31 4 31 5 15 4 75
0 2 0 31 3 15 5 15 3 27
0 3 0 31 2 7 5 15 2 20
1 0 0 31 5 31 5 31 5 75
1 1 0 31 4 15 5 15 5 75
1 2 0 31 3 7 5 15 4 27
1 3 0 31 2 3 5 15 3 20
2 0 0 31 5 15 5 63 5 75
2 1 0 31 4 7 5 31 5 75
2 2 0 31 3 3 5 15 5 27
2 3 0 31 2 1 5 15 4 20
0 1 1 31 5 31 5 15 4 75
1 1 1 31 5 15 5 15 5 75
2 1 1 31 5 7 5 31 5 75
0 0 1 31 5 63 5 15 5 75
1 2 1 31 3 7 5 15 4 27
2 3 1 31 2 1 5 15 4 20

/* testbench/tb_top.sv */
`timescale 1ns/1ps

module tb_top
    import tc_cfg_pkg::*, tc_ctrl_pkg::*;
();

    typedef struct packed {
        compute_cfg_t cfg;
        logic [5:0]   c_num;
        logic [2:0]   c_size;
        logic [5:0]   a_num;
        logic [2:0]   a_size;
        logic [5:0]   b_num;
        logic [2:0]   b_size;
        logic [7:0]   latency;  // Edges from B finish to done
    } golden_t;

    logic         clk;
    logic         rst;
    logic         start;
    compute_cfg_t compute_cfg;
    logic         req_ready;
    logic         load_finish;
    mem_req_t     mem_req;
    logic         req_valid;
    logic         busy;
    logic         done;

    golden_t      jobs[$];
    integer       seed;
    int           errors;
    int           pass_cnt;
    int           fail_cnt;
    int           cycle = 0;
    int           cycle_limit = 200;

    clk_gen clk_gen_i (
        .clk (clk)
    );

    tensor_sched_top tensor_sched_top_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .compute_cfg (compute_cfg),
        .req_ready   (req_ready),
        .load_finish (load_finish),
        .mem_req     (mem_req),
        .req_valid   (req_valid),
        .busy        (busy),
        .done        (done)
    );

    task automatic read_golden();
        int    fd;
        int    n;
        int    f_shape, f_type, f_mixed, f_cn, f_cs, f_an, f_as, f_bn, f_bs, f_lat;
        string line;
        golden_t g;
        fd = $fopen("testbench/sched_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/sched_golden.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d", f_shape, f_type,
                                f_mixed, f_cn, f_cs, f_an, f_as, f_bn, f_bs, f_lat);
                    if (n == 10) begin
                        g.cfg.compute_shape = compute_shape_e'(f_shape[1:0]);
                        g.cfg.data_type     = data_type_e'(f_type[1:0]);
                        g.cfg.mixed         = f_mixed[0];
                        g.c_num   = 6'(f_cn);
                        g.c_size  = 3'(f_cs);
                        g.a_num   = 6'(f_an);
                        g.a_size  = 3'(f_as);
                        g.b_num   = 6'(f_bn);
                        g.b_size  = 3'(f_bs);
                        g.latency = 8'(f_lat);
                        jobs.push_back(g);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Memory side of one load with stall, accept and finish
    task automatic serve_load(input int idx, input mat_sel_e sel, input logic [31:0] base,
                              input logic [5:0] num, input logic [2:0] size);
        mem_req_t exp;
        mem_req_t held;
        int       delay;
        int       gap;
        exp.sel        = sel;
        exp.base       = base;
        exp.burst_num  = num;
        exp.burst_size = size;
        while (!req_valid) begin
            @(negedge clk);
        end
        if (mem_req !== exp) begin
            $display("FAILED at %0t: job %0d %s request expected %h, got %h",
                     $time, idx, sel.name(), exp, mem_req);
            errors++;
        end
        held  = mem_req;
        delay = $unsigned($random(seed)) % 6;
        for (int i = 0; i < delay; i++) begin
            @(negedge clk);
            if (!req_valid || mem_req !== held) begin
                $display("FAILED at %0t: job %0d %s request moved while ready was low",
                         $time, idx, sel.name());
                errors++;
            end
        end
        req_ready = 1'b1;
        @(negedge clk);
        req_ready = 1'b0;
        if (req_valid) begin
            $display("FAILED at %0t: job %0d %s valid still high after acceptance",
                     $time, idx, sel.name());
            errors++;
        end
        gap = $unsigned($random(seed)) % 8 + 1;
        for (int i = 1; i < gap; i++) begin
            @(negedge clk);
        end
        load_finish = 1'b1;
        @(negedge clk);
        load_finish = 1'b0;
    endtask

    task automatic run_job(input int idx);
        golden_t g;
        int      err_before;
        int      lat;
        g          = jobs[idx];
        err_before = errors;
        compute_cfg = g.cfg;
        start       = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (busy !== 1'b1) begin
            $display("FAILED at %0t: job %0d busy low after start", $time, idx);
            errors++;
        end
        serve_load(idx, MAT_C, BASE_C, g.c_num, g.c_size);
        // Start while busy must be ignored
        compute_cfg = '{compute_shape: M8K16N32, data_type: INT4, mixed: 1'b1};
        start       = 1'b1;
        @(negedge clk);
        start = 1'b0;
        serve_load(idx, MAT_A, BASE_A, g.a_num, g.a_size);
        serve_load(idx, MAT_B, BASE_B, g.b_num, g.b_size);
        lat = 0;
        while (!done) begin
            @(negedge clk);
            lat++;
            if (req_valid) begin
                $display("FAILED at %0t: job %0d unexpected request during compute",
                         $time, idx);
                errors++;
            end
        end
        if (lat != int'(g.latency)) begin
            $display("FAILED at %0t: job %0d latency expected %0d, got %0d",
                     $time, idx, g.latency, lat);
            errors++;
        end
        @(negedge clk);
        if (done || busy) begin
            $display("FAILED at %0t: job %0d done or busy high after the done pulse",
                     $time, idx);
            errors++;
        end
        if (errors == err_before) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("Job %0d shape %0d type %0d mixed %0d latency %0d: %s", idx,
                 g.cfg.compute_shape, g.cfg.data_type, g.cfg.mixed, lat,
                 (errors == err_before) ? "passed" : "failed");
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("Timeout: the run did not end within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        rst         = 1'b0;
        start       = 1'b0;
        compute_cfg = '0;
        req_ready   = 1'b0;
        load_finish = 1'b0;
        seed        = 32929;
        errors      = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        read_golden();
        if (jobs.size() > 0) begin
            cycle_limit = jobs.size() * 200;
        end
        repeat (4) @(negedge clk);
        if (req_valid !== 1'b0 || busy !== 1'b0 || done !== 1'b0) begin
            $display("FAILED at %0t: valid, busy or done high in reset", $time);
            errors++;
            fail_cnt++;
            $display("Reset: failed");
        end else begin
            pass_cnt++;
            $display("Reset: passed");
        end
        rst = 1'b1;
        @(negedge clk);
        for (int i = 0; i < jobs.size(); i++) begin
            run_job(i);  // Back to back with no idle gap
        end
        $display("Tests: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, errors);
        if (errors == 0 && fail_cnt == 0 && jobs.size() > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* testbench/tensor_sched_asserts.sv */
`timescale 1ns/1ps

module tensor_sched_asserts
    import tc_ctrl_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input mem_req_t mem_req,
    input logic     req_valid,
    input logic     req_ready,
    input logic     done
);

    // A stalled request keeps valid and its descriptor
    a_req_held: assert property (@(posedge clk) disable iff (!rst)
        req_valid && !req_ready |=> req_valid && $stable(mem_req))
        else $error("request dropped or changed while ready was low");

    a_sel_onehot: assert property (@(posedge clk) disable iff (!rst)
        req_valid |-> $onehot(mem_req.sel))
        else $error("matrix select is not one-hot on a valid request");

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

endmodule

bind tensor_sched_top tensor_sched_asserts tensor_sched_asserts_i (
    .clk       (clk),
    .rst       (rst),
    .mem_req   (mem_req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .done      (done)
);

/* verilog/burst_planner.sv */
`timescale 1ns/1ps

module burst_planner
    import tc_cfg_pkg::*, tc_ctrl_pkg::*;
(
    input  compute_cfg_t cfg,
    input  mat_sel_e     cur_mat,
    output mem_req_t     plan
);

    logic [5:0]  elem_bits;
    logic [5:0]  c_beat_bytes;
    logic [5:0]  m_rows;
    logic [5:0]  n_cols;
    logic [15:0] a_bits;
    logic [6:0]  a_beats;
    logic [15:0] b_bytes;
    logic [6:0]  b_beats;
    logic [5:0]  b_beat_bytes;

    // Beat bytes are always a power of two up to 32
    function automatic logic [2:0] log2_bytes(input logic [5:0] bytes);
        logic [2:0] r;
        r = 3'd0;
        for (int i = 0; i < 6; i++) begin
            if (bytes[i]) begin
                r = 3'(i);
            end
        end
        return r;
    endfunction

    always_comb begin
        case (cfg.data_type)
            FP32:    elem_bits = 6'(ELEM_BITS_FP32);
            FP16:    elem_bits = 6'(ELEM_BITS_FP16);
            INT8:    elem_bits = 6'(ELEM_BITS_INT8);
            default: elem_bits = 6'(ELEM_BITS_INT4);
        endcase

        case (cfg.compute_shape)
            M32K16N8: begin
                m_rows = 6'd32;
                n_cols = 6'd8;
            end
            M16K16N16: begin
                m_rows = 6'd16;
                n_cols = 6'd16;
            end
            default: begin
                m_rows = 6'd8;
                n_cols = 6'd32;
            end
        endcase

        c_beat_bytes = (cfg.data_type == FP16 && cfg.mixed) ? 6'(ELEM_BITS_FP32) : elem_bits;

        // A is M x K with K fixed at 16
        a_bits  = 16'(m_rows) * 16'd16 * 16'(elem_bits);
        a_beats = 7'(a_bits / 16'(BEAT_BYTES * 8));

        // B is K x N and never takes fewer than 16 beats
        b_bytes = 16'd16 * 16'(n_cols) * 16'(elem_bits) / 16'd8;
        if (b_bytes / 16'(BEAT_BYTES) >= 16'd16) begin
            b_beats      = 7'(b_bytes / 16'(BEAT_BYTES));
            b_beat_bytes = 6'(BEAT_BYTES);
        end else begin
            b_beats      = 7'd16;
            b_beat_bytes = 6'(b_bytes / 16);  // Narrow beats for small B
        end

        plan.sel = cur_mat;
        case (cur_mat)
            MAT_C: begin
                plan.base       = BASE_C;
                plan.burst_num  = 6'd31;  // One beat per C row pair
                plan.burst_size = log2_bytes(c_beat_bytes);
            end
            MAT_A: begin
                plan.base       = BASE_A;
                plan.burst_num  = 6'(a_beats - 7'd1);
                plan.burst_size = log2_bytes(6'(BEAT_BYTES));
            end
            default: begin
                plan.base       = BASE_B;
                plan.burst_num  = 6'(b_beats - 7'd1);
                plan.burst_size = log2_bytes(b_beat_bytes);
            end
        endcase
    end

endmodule

/* verilog/mem_req_port.sv */
`timescale 1ns/1ps

module mem_req_port
    import tc_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     issue,
    input  mem_req_t plan,
    input  logic     req_ready,
    output mem_req_t mem_req,
    output logic     req_valid
);

    // Valid holds until the first edge with ready high
    always_ff @(posedge clk) begin
        if (!rst) begin
            req_valid <= 1'b0;
        end else if (issue) begin
            req_valid <= 1'b1;
        end else if (req_valid && req_ready) begin
            req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            mem_req <= plan;  // Stays put while the memory stalls
        end
    end

endmodule

/* verilog/phase_sequencer.sv */
`timescale 1ns/1ps

module phase_sequencer
    import tc_cfg_pkg::*, tc_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  compute_cfg_t compute_cfg,
    input  logic         load_finish,
    output compute_cfg_t cfg,
    output mat_sel_e     cur_mat,
    output logic         issue,
    output logic         busy,
    output logic         done
);

    sched_state_e state;
    sched_state_e next_state;
    logic [7:0]   cnt;         // Shared by SYSTOLIC and WAIT_WRITE
    logic [7:0]   sys_cycles;
    logic         enter_load;

    always_comb begin
        case (cfg.data_type)
            FP32, FP16: sys_cycles = SYSTOLIC_CYCLES_FLOAT;
            INT8:       sys_cycles = SYSTOLIC_CYCLES_INT8;
            default:    sys_cycles = SYSTOLIC_CYCLES_INT4;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start) begin
                    next_state = READ_C;
                end
            end
            READ_C: begin
                if (load_finish) begin
                    next_state = LOAD_A;
                end
            end
            LOAD_A: begin
                if (load_finish) begin
                    next_state = LOAD_B;
                end
            end
            LOAD_B: begin
                if (load_finish) begin
                    next_state = SYSTOLIC;
                end
            end
            SYSTOLIC: begin
                if (cnt == 8'd0) begin
                    next_state = (cfg.data_type == INT4) ? ACCUMULATE : WAIT_WRITE;
                end
            end
            ACCUMULATE: next_state = WAIT_WRITE;  // Extra partial-sum merge for INT4
            WAIT_WRITE: begin
                if (cnt == 8'd0) begin
                    next_state = WRITE_BACK;
                end
            end
            WRITE_BACK: next_state = FINISH;
            FINISH:     next_state = IDLE;
            default:    next_state = IDLE;
        endcase
    end

    assign enter_load = (next_state != state) &&
                        (next_state inside {READ_C, LOAD_A, LOAD_B});

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= IDLE;
            cnt   <= 8'd0;
            issue <= 1'b0;
        end else begin
            state <= next_state;
            issue <= enter_load;  // High in the first cycle of each load
            if (state == LOAD_B && next_state == SYSTOLIC) begin
                cnt <= sys_cycles - 8'd1;
            end else if (next_state == WAIT_WRITE && state != WAIT_WRITE) begin
                cnt <= WAIT_WRITE_CYCLES - 8'd1;
            end else if (cnt != 8'd0) begin
                cnt <= cnt - 8'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            cfg <= compute_cfg;
        end
        if (enter_load) begin
            case (next_state)
                READ_C:  cur_mat <= MAT_C;
                LOAD_A:  cur_mat <= MAT_A;
                default: cur_mat <= MAT_B;
            endcase
        end
    end

    assign busy = (state != IDLE);
    assign done = (state == FINISH);

endmodule

/* verilog/tc_cfg_pkg.sv */
package tc_cfg_pkg;

    // Tile shape of one compute job
    typedef enum logic [1:0] {
        M32K16N8  = 2'd0,
        M16K16N16 = 2'd1,
        M8K16N32  = 2'd2
    } compute_shape_e;

    // Element type of the A and B operands
    typedef enum logic [1:0] {
        FP32 = 2'd0,
        FP16 = 2'd1,
        INT8 = 2'd2,
        INT4 = 2'd3
    } data_type_e;

    typedef struct packed {
        compute_shape_e compute_shape;
        data_type_e     data_type;
        logic           mixed;         // FP16 inputs with FP32 accumulation
    } compute_cfg_t;

    localparam int ELEM_BITS_FP32 = 32;
    localparam int ELEM_BITS_FP16 = 16;
    localparam int ELEM_BITS_INT8 = 8;
    localparam int ELEM_BITS_INT4 = 4;

    localparam int BEAT_BYTES = 32;  // 256 bit memory beat

    localparam logic [31:0] BASE_C = 32'h0001_0000;
    localparam logic [31:0] BASE_A = 32'h0010_0000;
    localparam logic [31:0] BASE_B = 32'h0100_0000;

endpackage

/* verilog/tc_ctrl_pkg.sv */
package tc_ctrl_pkg;

    typedef enum logic [3:0] {
        IDLE       = 4'd0,
        READ_C     = 4'd1,
        LOAD_A     = 4'd2,
        LOAD_B     = 4'd3,
        SYSTOLIC   = 4'd4,
        ACCUMULATE = 4'd5,
        WAIT_WRITE = 4'd6,
        WRITE_BACK = 4'd7,
        FINISH     = 4'd8
    } sched_state_e;

    // One-hot matrix select as seen on the memory port
    typedef enum logic [2:0] {
        MAT_C = 3'b001,
        MAT_B = 3'b010,
        MAT_A = 3'b100
    } mat_sel_e;

    typedef struct packed {
        mat_sel_e    sel;
        logic [31:0] base;
        logic [5:0]  burst_num;   // Beats minus one
        logic [2:0]  burst_size;  // Log2 of beat bytes
    } mem_req_t;

    localparam logic [7:0] SYSTOLIC_CYCLES_FLOAT = 8'd64;
    localparam logic [7:0] SYSTOLIC_CYCLES_INT8  = 8'd16;
    localparam logic [7:0] SYSTOLIC_CYCLES_INT4  = 8'd8;
    localparam logic [7:0] WAIT_WRITE_CYCLES     = 8'd10;

endpackage

/* verilog/tensor_sched_top.sv */
`timescale 1ns/1ps

module tensor_sched_top
    import tc_cfg_pkg::*, tc_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  compute_cfg_t compute_cfg,
    input  logic         req_ready,
    input  logic         load_finish,
    output mem_req_t     mem_req,
    output logic         req_valid,
    output logic         busy,
    output logic         done
);

    compute_cfg_t cfg;
    mat_sel_e     cur_mat;
    logic         issue;
    mem_req_t     plan;

    phase_sequencer phase_sequencer_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .compute_cfg (compute_cfg),
        .load_finish (load_finish),
        .cfg         (cfg),
        .cur_mat     (cur_mat),
        .issue       (issue),
        .busy        (busy),
        .done        (done)
    );

    burst_planner burst_planner_i (
        .cfg     (cfg),
        .cur_mat (cur_mat),
        .plan    (plan)
    );

    mem_req_port mem_req_port_i (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .plan      (plan),
        .req_ready (req_ready),
        .mem_req   (mem_req),
        .req_valid (req_valid)
    );

endmodule
